//--- logic/axis_cfg_pkg.sv
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// size defaults for the two-source stream router
// the top level takes its parameter defaults from here
// index widths follow from the lane count and the source count
////////////////////////////////////////////////////////////////////////////

package axis_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // base sizes
  ////////////////////////////////////////////////////////////////////////////

  // number of output lanes behind the fan-out
  localparam int DEF_NUM_LANES = 6;

  // payload width in bits
  localparam int DEF_DATA_WIDTH = 32;

  ////////////////////////////////////////////////////////////////////////////
  // derived widths
  ////////////////////////////////////////////////////////////////////////////

  // dest index rounded up to a whole bit count
  // with 6 lanes the codes 6 and 7 exist but address nothing
  localparam int DEST_W = $clog2(DEF_NUM_LANES);

  // source number for the two merged inputs
  localparam int SRC_W = $clog2(2);

endpackage

`default_nettype wire

//--- logic/axis_types_pkg.sv
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// packed beat layouts used on every stream of the router
// shared by the RTL and the testbench so both see the same fields
////////////////////////////////////////////////////////////////////////////

package axis_types_pkg;

  import axis_cfg_pkg::*;

  // beat as a source presents it
  // dest picks the output lane
  typedef struct packed {
    logic [DEF_DATA_WIDTH-1:0] data;
    logic [DEST_W-1:0]         dest;
  } in_beat_t;

  // beat as a lane delivers it
  // src tells which input it came from
  typedef struct packed {
    logic [DEF_DATA_WIDTH-1:0] data;
    logic [SRC_W-1:0]          src;
  } lane_beat_t;

  // merged beat between fan-in and fan-out
  // dest still needed for steering and src added by the arbiter
  typedef struct packed {
    logic [DEF_DATA_WIDTH-1:0] data;
    logic [DEST_W-1:0]         dest;
    logic [SRC_W-1:0]          src;
  } route_beat_t;

endpackage

`default_nettype wire

//--- logic/axis_fifo.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// synchronous first-word-fall-through stream FIFO
// payload type set per instance so one block serves source and lane beats
// FIFO_DEPTH must be a power of two and at least 2
////////////////////////////////////////////////////////////////////////////

module axis_fifo #(
  parameter type beat_t     = logic,
  parameter int  FIFO_DEPTH = 4
) (
  input  logic  axis_clk,
  input  logic  arst_n,

  // write side
  input  logic  in_valid,
  output logic  in_ready,
  input  beat_t in_beat,

  // read side
  output logic  out_valid,
  input  logic  out_ready,
  output beat_t out_beat
);

  // address bits
  // pointers carry one extra wrap bit on top
  localparam int AW = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  beat_t       mem [FIFO_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  logic        full;
  logic        empty;
  logic        wr_en;
  logic        rd_en;

  // same address on both pointers
  // wrap bits decide between empty and full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////////////////////

  // full FIFO still takes a beat when the head leaves this cycle
  assign in_ready  = ~full | out_ready;

  // head entry shown straight from the array
  assign out_valid = ~empty;
  assign out_beat  = mem[rd_ptr[AW-1:0]];

  assign wr_en = in_valid & in_ready;
  assign rd_en = out_valid & out_ready;

  // payload write
  // on a full read+write the slot under rd_ptr is consumed and refilled at once
  always_ff @(posedge axis_clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= in_beat;
    end
  end

  // pointer update
  always_ff @(posedge axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/axis_fan_in.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// round-robin merge of two source streams into one routed stream
// purely combinational on the data path with zero cycles of latency
// the winning source number is stamped into the src field
////////////////////////////////////////////////////////////////////////////

module axis_fan_in
  import axis_cfg_pkg::*;
  import axis_types_pkg::*;
(
  input  logic              axis_clk,
  input  logic              arst_n,

  // source side
  input  logic        [1:0] in_valid,
  output logic        [1:0] in_ready,
  input  in_beat_t    [1:0] in_beat,

  // merged side
  output logic              merged_valid,
  input  logic              merged_ready,
  output route_beat_t       merged_beat
);

  ////////////////////////////////////////////////////////////////////////////
  // arbitration state
  ////////////////////////////////////////////////////////////////////////////

  // source served by the last transfer
  logic [SRC_W-1:0] last_q;

  // grant frozen while the merged beat waits for ready
  logic             lock_q;
  logic [SRC_W-1:0] lock_src_q;

  logic [SRC_W-1:0] arb_src;
  logic [SRC_W-1:0] grant;
  logic             xfer;

  // fresh pick
  // a tie goes to the source not served last
  always_comb begin
    if (&in_valid) begin
      arb_src = ~last_q;
    end else if (in_valid[1]) begin
      arb_src = SRC_W'(1);
    end else begin
      arb_src = SRC_W'(0);
    end
  end

  // keep the stalled source so the beat stays stable
  assign grant = lock_q ? lock_src_q : arb_src;

  ////////////////////////////////////////////////////////////////////////////
  // stream mux
  ////////////////////////////////////////////////////////////////////////////

  assign merged_valid = in_valid[grant];

  always_comb begin
    merged_beat.data = in_beat[grant].data;
    merged_beat.dest = in_beat[grant].dest;
    merged_beat.src  = grant;
  end

  // only the granted source sees ready
  always_comb begin
    in_ready        = '0;
    in_ready[grant] = merged_ready;
  end

  assign xfer = merged_valid & merged_ready;

  ////////////////////////////////////////////////////////////////////////////
  // pointer and lock update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      // source 0 wins the first tie
      last_q     <= SRC_W'(1);
      lock_q     <= 1'b0;
      lock_src_q <= '0;
    end else begin
      if (xfer) begin
        // advance only after a real transfer
        last_q <= grant;
        lock_q <= 1'b0;
      end else if (merged_valid) begin
        // stalled downstream
        lock_q     <= 1'b1;
        lock_src_q <= grant;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/axis_fan_out.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// steers the merged stream to one output lane by its dest index
// zero cycles of latency and all lanes share one data bus
// beats with dest out of range are swallowed and counted
////////////////////////////////////////////////////////////////////////////

module axis_fan_out
  import axis_cfg_pkg::*;
  import axis_types_pkg::*;
#(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  logic                 axis_clk,
  input  logic                 arst_n,

  // merged side
  input  logic                 merged_valid,
  output logic                 merged_ready,
  input  route_beat_t          merged_beat,

  // lane side
  output logic [NUM_LANES-1:0] lane_valid,
  input  logic [NUM_LANES-1:0] lane_ready,
  output lane_beat_t           lane_beat,

  // saturating count of dropped beats
  output logic [15:0]          drop_count
);

  logic        in_range;
  logic        drop;
  logic [15:0] drop_q;

  assign in_range = (merged_beat.dest < NUM_LANES);

  // one-hot valid and ready taken from the addressed lane
  // no lane matches an out-of-range dest so ready stays high
  always_comb begin
    lane_valid   = '0;
    merged_ready = 1'b1;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (merged_beat.dest == DEST_W'(l)) begin
        lane_valid[l] = merged_valid;
        merged_ready  = lane_ready[l];
      end
    end
  end

  // same payload on every lane
  always_comb begin
    lane_beat.data = merged_beat.data;
    lane_beat.src  = merged_beat.src;
  end

  ////////////////////////////////////////////////////////////////////////////
  // drop counter
  ////////////////////////////////////////////////////////////////////////////

  assign drop = merged_valid & merged_ready & ~in_range;

  // sticks at all ones
  always_ff @(posedge axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      drop_q <= '0;
    end else if (drop && (drop_q != '1)) begin
      drop_q <= drop_q + 1'b1;
    end
  end

  assign drop_count = drop_q;

endmodule

`default_nettype wire

//--- logic/axis_router_top.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// two-source stream router on a single clock
// input FIFOs feed a round-robin fan-in then a dest fan-out into lane FIFOs
// each beat takes at least two cycles from source to lane
////////////////////////////////////////////////////////////////////////////

module axis_router_top
  import axis_cfg_pkg::*;
  import axis_types_pkg::*;
#(
  parameter int NUM_LANES  = DEF_NUM_LANES,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                           axis_clk,
  input  logic                           arst_n,

  // sources
  input  logic       [1:0]               s_valid,
  output logic       [1:0]               s_ready,
  input  in_beat_t   [1:0]               s_beat,

  // lanes
  output logic       [NUM_LANES-1:0]     m_valid,
  input  logic       [NUM_LANES-1:0]     m_ready,
  output lane_beat_t [NUM_LANES-1:0]     m_beat,

  output logic       [15:0]              drop_count
);

  ////////////////////////////////////////////////////////////////////////////
  // internal streams
  ////////////////////////////////////////////////////////////////////////////

  // input FIFO heads towards the fan-in
  logic        [1:0]           src_valid;
  logic        [1:0]           src_ready;
  in_beat_t    [1:0]           src_beat;

  // merged stream
  logic                        merged_valid;
  logic                        merged_ready;
  route_beat_t                 merged_beat;

  // fan-out towards the lane FIFOs
  logic        [NUM_LANES-1:0] lane_valid;
  logic        [NUM_LANES-1:0] lane_ready;
  lane_beat_t                  lane_beat;

  // one input FIFO per source
  for (genvar s = 0; s < 2; s++) begin : g_in_fifo
    axis_fifo #(
      .beat_t     (in_beat_t),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) in_fifo_inst (
      .axis_clk  (axis_clk),
      .arst_n    (arst_n),
      .in_valid  (s_valid[s]),
      .in_ready  (s_ready[s]),
      .in_beat   (s_beat[s]),
      .out_valid (src_valid[s]),
      .out_ready (src_ready[s]),
      .out_beat  (src_beat[s])
    );
  end

  // merge
  axis_fan_in axis_fan_in_inst (
    .axis_clk     (axis_clk),
    .arst_n       (arst_n),
    .in_valid     (src_valid),
    .in_ready     (src_ready),
    .in_beat      (src_beat),
    .merged_valid (merged_valid),
    .merged_ready (merged_ready),
    .merged_beat  (merged_beat)
  );

  // steer by dest
  axis_fan_out #(
    .NUM_LANES (NUM_LANES)
  ) axis_fan_out_inst (
    .axis_clk     (axis_clk),
    .arst_n       (arst_n),
    .merged_valid (merged_valid),
    .merged_ready (merged_ready),
    .merged_beat  (merged_beat),
    .lane_valid   (lane_valid),
    .lane_ready   (lane_ready),
    .lane_beat    (lane_beat),
    .drop_count   (drop_count)
  );

  // one output FIFO per lane
  // a full lane pushes back through the fan-in to the sources
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane_fifo
    axis_fifo #(
      .beat_t     (lane_beat_t),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) lane_fifo_inst (
      .axis_clk  (axis_clk),
      .arst_n    (arst_n),
      .in_valid  (lane_valid[l]),
      .in_ready  (lane_ready[l]),
      .in_beat   (lane_beat),
      .out_valid (m_valid[l]),
      .out_ready (m_ready[l]),
      .out_beat  (m_beat[l])
    );
  end

endmodule

`default_nettype wire

//--- tb/axis_router_checker.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// scoreboard for the stream router
// expected beats come from the source handshakes and are compared in order
////////////////////////////////////////////////////////////////////////////

module axis_router_checker
  import axis_cfg_pkg::*;
  import axis_types_pkg::*;
#(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  logic                       axis_clk,
  input  logic                       arst_n,
  input  logic       [1:0]           s_valid,
  input  logic       [1:0]           s_ready,
  input  in_beat_t   [1:0]           s_beat,
  input  logic       [NUM_LANES-1:0] m_valid,
  input  logic       [NUM_LANES-1:0] m_ready,
  input  lane_beat_t [NUM_LANES-1:0] m_beat,
  input  logic       [15:0]          drop_count,
  input  logic                       fair_mode,
  input  logic                       end_check,
  output int                         errors,
  output int                         stalls,
  output logic                       drained
);

  // ring buffer per lane and source pair
  localparam int QD = 1024;

  logic [DEF_DATA_WIDTH-1:0] exp_q [NUM_LANES*2][QD];
  int               wr_cnt [NUM_LANES*2];
  int               rd_cnt [NUM_LANES*2];
  int               pending = 0;
  int               exp_drops = 0;
  int               since_rst = 0;
  int               rst_edges = 0;
  int               fair_beats = 0;
  logic [SRC_W-1:0] fair_last = '0;

  // reference routing gives the lane number or -1 for a dropped beat
  function automatic int expected_lane(input logic [DEST_W-1:0] dest);
    return (int'(dest) < NUM_LANES) ? int'(dest) : -1;
  endfunction

  initial begin
    errors = 0;
    stalls = 0;
    for (int q = 0; q < NUM_LANES*2; q++) begin
      wr_cnt[q] = 0;
      rd_cnt[q] = 0;
    end
  end

  // nothing owed on any lane and every drop counted
  assign drained = (pending == 0) && (int'(drop_count) >= exp_drops);

  always @(posedge axis_clk) begin : compare
    int lane;
    int q;
    // idle ports from the second edge in reset to two edges after it
    if (((!arst_n && rst_edges > 0) || (arst_n && since_rst < 2)) &&
        (m_valid !== '0 || s_ready !== 2'b11 || drop_count !== 16'd0)) begin
      $display("FAIL @ %0t ns: reset state m_valid %b s_ready %b drop_count %0d",
               $time, m_valid, s_ready, drop_count);
      errors++;
    end
    rst_edges = arst_n ? 0 : rst_edges + 1;
    since_rst = arst_n ? since_rst + 1 : 0;

    ////////////////////////////////////////////////////////////////////////////
    // source handshakes push
    ////////////////////////////////////////////////////////////////////////////
    for (int s = 0; s < 2; s++) begin
      stalls += (s_valid[s] && !s_ready[s]) ? 1 : 0;
      if (s_valid[s] && s_ready[s]) begin
        lane = expected_lane(s_beat[s].dest);
        if (lane < 0) begin
          exp_drops++;
        end else begin
          q = lane*2 + s;
          exp_q[q][wr_cnt[q] % QD] = s_beat[s].data;
          wr_cnt[q]++;
          pending++;
        end
      end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lane handshakes pop and compare
    ////////////////////////////////////////////////////////////////////////////
    for (int l = 0; l < NUM_LANES; l++) begin
      if (m_valid[l] && m_ready[l]) begin
        q = l*2 + int'(m_beat[l].src);
        if (rd_cnt[q] == wr_cnt[q]) begin
          $display("unexpected beat on lane %0d at %0t ns, src %0d data %h",
                   l, $time, m_beat[l].src, m_beat[l].data);
          errors++;
        end else begin
          if (m_beat[l].data !== exp_q[q][rd_cnt[q] % QD]) begin
            $display("FAIL @ %0t ns: lane %0d src %0d data %h expected %h", $time, l,
                     m_beat[l].src, m_beat[l].data, exp_q[q][rd_cnt[q] % QD]);
            errors++;
          end
          rd_cnt[q]++;
          pending--;
        end
        // src must alternate once both input FIFOs are busy
        if (fair_mode && l == 2) begin
          if (fair_beats >= 4 && m_beat[l].src == fair_last) begin
            $display("FAIL @ %0t ns: lane 2 got src %0d twice in a row", $time, fair_last);
            errors++;
          end
          fair_last = m_beat[l].src;
          fair_beats++;
        end
      end
    end
    if (!fair_mode) begin
      fair_beats = 0;
    end

    // drop counter against the reference at the end of a test
    if (end_check && drop_count !== 16'(exp_drops)) begin
      $display("FAIL @ %0t ns: drop_count %0d expected %0d", $time, drop_count, exp_drops);
      errors++;
    end
  end

endmodule

`default_nettype wire

//--- tb/axis_router_tb.sv
`timescale 1ns/1ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// testbench for the two-source stream router
// runs the tests in order, the checker instance compares lane beats
////////////////////////////////////////////////////////////////////////////

module axis_router_tb
  import axis_cfg_pkg::*;
  import axis_types_pkg::*;
();

  localparam int NUM_LANES  = DEF_NUM_LANES;
  localparam int FIFO_DEPTH = 4;

  // beats per source
  localparam int N_RANDOM = 150;
  localparam int N_DROP   = 60;
  localparam int N_FAIR   = 40;
  localparam int TIMEOUT_CYCLES =
    20 * 2 * (NUM_LANES + 2 * N_RANDOM + N_DROP + N_FAIR) + 1000;

  // dest patterns
  localparam int MODE_DIRECTED = 0;
  localparam int MODE_IN_RANGE = 1;
  localparam int MODE_ANY      = 2;
  localparam int MODE_FAIR     = 3;

  logic                       axis_clk;
  logic                       arst_n;
  logic       [1:0]           s_valid;
  logic       [1:0]           s_ready;
  in_beat_t   [1:0]           s_beat;
  logic       [NUM_LANES-1:0] m_valid;
  logic       [NUM_LANES-1:0] m_ready;
  lane_beat_t [NUM_LANES-1:0] m_beat;
  logic       [15:0]          drop_count;
  logic                       fair_mode;
  logic                       end_check;
  logic                       drained;
  int                         errors;
  int                         stalls;

  integer seed      = 32'h4d41_ccd8;
  int     tb_errors = 0;
  int     passed    = 0;
  int     failed    = 0;
  int     cycles    = 0;

  initial begin
    axis_clk = 1'b0;
    forever #4 axis_clk = ~axis_clk;
  end

  axis_router_top #(
    .NUM_LANES  (NUM_LANES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) axis_router_top_inst (.*);

  axis_router_checker #(
    .NUM_LANES (NUM_LANES)
  ) checker_inst (.*);

  function automatic logic [DEST_W-1:0] pick_dest(input int mode, input int idx);
    case (mode)
      MODE_DIRECTED: return DEST_W'(idx);
      MODE_FAIR:     return DEST_W'(2);
      // full code range, 6 and 7 get dropped
      MODE_ANY:      return DEST_W'($random(seed));
      default:       return DEST_W'($unsigned($random(seed)) % NUM_LANES);
    endcase
  endfunction

  // both sources offer n_beats each, m_ready random under back-pressure
  task automatic run_traffic(input int n_beats, input int mode, input bit back_pressure);
    int left [2];
    int idx [2];
    bit xfer [2];
    bit idle;
    for (int s = 0; s < 2; s++) begin
      left[s] = n_beats;
      idx[s]  = 0;
    end
    while (left[0] > 0 || left[1] > 0 || s_valid != 2'b00) begin
      @(posedge axis_clk);
      for (int s = 0; s < 2; s++) begin
        xfer[s] = s_valid[s] && s_ready[s];
      end
      @(negedge axis_clk);
      for (int s = 0; s < 2; s++) begin
        // an offered beat is held until taken
        if (!s_valid[s] || xfer[s]) begin
          idle = (mode == MODE_IN_RANGE || mode == MODE_ANY) && (($random(seed) & 3) == 0);
          if (left[s] > 0 && !idle) begin
            s_beat[s].dest = pick_dest(mode, idx[s]);
            s_beat[s].data = (mode == MODE_DIRECTED) ?
                             DEF_DATA_WIDTH'({16'hd1e0, 8'(s), 8'(idx[s])}) : $random(seed);
            s_valid[s] = 1'b1;
            left[s]--;
            idx[s]++;
          end else begin
            s_valid[s] = 1'b0;
          end
        end
      end
      // each lane ready about one cycle in four
      m_ready = back_pressure ? NUM_LANES'($random(seed) & $random(seed)) : '1;
    end
  endtask

  task automatic finish_test(input string name, input int err_mark);
    m_ready = '1;
    while (!drained) @(negedge axis_clk);
    end_check = 1'b1;
    @(negedge axis_clk);
    end_check = 1'b0;
    if (errors + tb_errors == err_mark) begin
      passed++;
      $display("test %s: pass", name);
    end else begin
      failed++;
      $display("test %s: fail", name);
    end
  endtask

  initial begin : stimulus
    int err_mark;
    int stall_mark;
    arst_n    = 1'b0;
    s_valid   = '0;
    s_beat    = '0;
    m_ready   = '1;
    fair_mode = 1'b0;
    end_check = 1'b0;
    repeat (10) @(posedge axis_clk);
    @(negedge axis_clk);
    arst_n = 1'b1;
    repeat (3) @(negedge axis_clk);
    finish_test("reset state", 0);

    err_mark = errors + tb_errors;
    run_traffic(NUM_LANES, MODE_DIRECTED, 1'b0);
    finish_test("directed routing", err_mark);

    err_mark = errors + tb_errors;
    run_traffic(N_RANDOM, MODE_IN_RANGE, 1'b0);
    finish_test("random traffic", err_mark);

    err_mark   = errors + tb_errors;
    stall_mark = stalls;
    run_traffic(N_RANDOM, MODE_IN_RANGE, 1'b1);
    if (stalls == stall_mark) begin
      $display("s_ready never dropped while the lanes were stalled");
      tb_errors++;
    end
    finish_test("random back-pressure", err_mark);

    err_mark = errors + tb_errors;
    run_traffic(N_DROP, MODE_ANY, 1'b0);
    finish_test("out-of-range drops", err_mark);

    err_mark  = errors + tb_errors;
    fair_mode = 1'b1;
    run_traffic(N_FAIR, MODE_FAIR, 1'b0);
    finish_test("fairness", err_mark);
    fair_mode = 1'b0;

    $display("tests passed: %0d failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // cycle budget scales with the traffic volume
  initial begin : watchdog
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge axis_clk);
      cycles++;
    end
    $display("timeout: traffic did not drain");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
logic/axis_cfg_pkg.sv
logic/axis_types_pkg.sv
logic/axis_fifo.sv
logic/axis_fan_in.sv
logic/axis_fan_out.sv
logic/axis_router_top.sv
tb/axis_router_checker.sv
tb/axis_router_tb.sv

//--- Bender.yml
package:
  name: axis_router

sources:
  - logic/axis_cfg_pkg.sv
  - logic/axis_types_pkg.sv
  - logic/axis_fifo.sv
  - logic/axis_fan_in.sv
  - logic/axis_fan_out.sv
  - logic/axis_router_top.sv
  - target: test
    files:
      - tb/axis_router_checker.sv
      - tb/axis_router_tb.sv
